// ==== verilog/prefilter_pkg.sv ====
`default_nettype none

package prefilter_pkg;

	localparam int NUM_WIN = 8; // Windows per beat
	localparam int NUM_LEN = 4; // Length banks
	localparam int MAX_NBITS = 15; // Widest bitmap bit address
	localparam int LEN_SEL_W = $clog2(NUM_LEN);

	// Byte 0 in bits 7:0 is the earliest byte of the beat
	typedef logic [63:0] beat_t;

	// Newest byte of the window sits in bits 63:56
	typedef logic [63:0] window_t;

	typedef window_t [NUM_WIN-1:0] window_vec_t;

	typedef struct packed {
		logic en;
		logic [LEN_SEL_W-1:0] len_sel; // Target bank
		logic [MAX_NBITS-1:0] bit_addr;
		logic value; // 1 sets, 0 clears
	} bitmap_wr_t;

	typedef struct packed {
		logic [NUM_WIN-1:0] valid;
		logic [NUM_WIN-1:0] hit;
	} win_res_t;

	typedef win_res_t [NUM_LEN-1:0] res_vec_t;

	// XOR of the key in nbits-wide chunks from bit 0 upward.
	// Bit b lands in chunk position b mod nbits, which zero-pads the last chunk.
	function automatic logic [MAX_NBITS-1:0] fold_key(
		input window_t key,
		input int unsigned nbits
	);
		logic [MAX_NBITS-1:0] acc;

		acc = '0;
		for (int b = 0; b < $bits(window_t); b++) begin
			acc[b % nbits] ^= key[b];
		end
		return acc;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/window_slicer.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_slicer import prefilter_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  beat_t       din,
	input  logic        din_valid,
	output window_vec_t win,
	output logic        prev_valid
);

	beat_t prev_beat;

	always_ff @(posedge clk) begin
		prev_beat <= din; // Taken every clock, valid or not
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_valid <= 1'b0;
		end else begin
			prev_valid <= din_valid;
		end
	end

	// Window i ends at byte i of the current beat.
	// Its older bytes come from the top of the previous beat.
	for (genvar i = 0; i < NUM_WIN; i++) begin : g_win
		localparam int CUR_BITS = 8 * (i + 1); // Bits taken from the current beat

		if (i == NUM_WIN - 1) begin : g_full
			assign win[i] = din; // Current beat alone
		end else begin : g_split
			assign win[i] = {din[CUR_BITS-1:0], prev_beat[$bits(beat_t)-1:CUR_BITS]};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bitmap_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmap_table import prefilter_pkg::*; #(
	parameter int LEN_BYTES = 8,
	parameter int NBITS     = 15
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  window_t              key0,
	input  window_t              key1,
	input  logic                 look0,
	input  logic                 look1,
	input  logic                 wr_en,
	input  logic [MAX_NBITS-1:0] wr_addr,
	input  logic                 wr_value,
	output logic                 hit0,
	output logic                 hit1
);

	localparam int WORDS = 2 ** (NBITS - 3); // 8-bit words
	localparam int KEY_W = $bits(window_t);

	// Keeps the newest LEN_BYTES bytes of a window
	localparam window_t KEY_MASK = {KEY_W{1'b1}} << (KEY_W - 8 * LEN_BYTES);

	if (NBITS < 3 || NBITS > MAX_NBITS) begin : g_bad_nbits
		$error("bitmap_table: NBITS out of range");
	end
	if (LEN_BYTES < 1 || LEN_BYTES > 8) begin : g_bad_len
		$error("bitmap_table: LEN_BYTES out of range");
	end

	logic [7:0] mem [WORDS];

	window_t              key    [2];
	logic [MAX_NBITS-1:0] fold   [2];
	logic [NBITS-1:0]     addr   [2];
	logic                 bit_rd [2];

	logic [NBITS-4:0] wr_word_addr;
	logic [2:0]       wr_bit_sel;
	logic [7:0]       wr_word;

	assign key[0] = key0;
	assign key[1] = key1;

	// Two lookup ports with identical masking and fold
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			fold[p]   = fold_key(key[p] & KEY_MASK, NBITS);
			addr[p]   = fold[p][NBITS-1:0];
			bit_rd[p] = mem[addr[p][NBITS-1:3]][addr[p][2:0]];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hit0 <= 1'b0;
			hit1 <= 1'b0;
		end else begin
			hit0 <= look0 & bit_rd[0];
			hit1 <= look1 & bit_rd[1];
		end
	end

	assign wr_word_addr = wr_addr[NBITS-1:3];
	assign wr_bit_sel   = wr_addr[2:0];

	// Read-modify-write of the addressed word
	always_comb begin
		wr_word = mem[wr_word_addr];
		wr_word[wr_bit_sel] = wr_value;
	end

	// Bitmap starts empty and is filled through the write port
	initial begin
		for (int w = 0; w < WORDS; w++) begin
			mem[w] = 8'h00;
		end
	end

	// Lookups on the write edge still see the old word
	always @(posedge clk) begin
		if (wr_en) begin
			mem[wr_word_addr] <= wr_word;
		end
	end

	a_wr_addr_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> ((wr_addr >> NBITS) == '0)
	) else $error("bitmap write address beyond table size");

endmodule

`default_nettype wire

// ==== verilog/length_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module length_bank import prefilter_pkg::*; #(
	parameter int BANK_ID   = 0,
	parameter int LEN_BYTES = 8,
	parameter int NBITS     = 15
) (
	input  logic        clk,
	input  logic        arst_n,
	input  window_vec_t win,
	input  logic        din_valid,
	input  logic        prev_valid,
	input  bitmap_wr_t  wr,
	output win_res_t    res
);

	logic [NUM_WIN-1:0] look;
	logic [NUM_WIN-1:0] valid_q;
	logic [NUM_WIN-1:0] hit;
	logic               bank_wr;

	assign bank_wr = wr.en && (wr.len_sel == LEN_SEL_W'(BANK_ID));

	// Staircase rule; short windows need the previous beat only when the
	// key reaches back into it
	for (genvar i = 0; i < NUM_WIN; i++) begin : g_look
		localparam bit IN_BEAT = (i + 1 >= LEN_BYTES); // Key fits in current beat

		assign look[i] = din_valid & (IN_BEAT | prev_valid);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= look;
		end
	end

	// Table k serves windows 2k and 2k+1
	for (genvar k = 0; k < NUM_WIN / 2; k++) begin : g_table
		bitmap_table #(
			.LEN_BYTES(LEN_BYTES),
			.NBITS    (NBITS)
		) u_table (
			.clk     (clk),
			.arst_n  (arst_n),
			.key0    (win[2*k]),
			.key1    (win[2*k+1]),
			.look0   (look[2*k]),
			.look1   (look[2*k+1]),
			.wr_en   (bank_wr),
			.wr_addr (wr.bit_addr),
			.wr_value(wr.value),
			.hit0    (hit[2*k]),
			.hit1    (hit[2*k+1])
		);
	end

	assign res.valid = valid_q;
	assign res.hit   = hit;

	a_hit_needs_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		(res.hit & ~res.valid) == '0
	) else $error("window hit flagged without window valid");

endmodule

`default_nettype wire

// ==== verilog/prefix_filter_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_filter_top import prefilter_pkg::*; #(
	parameter int BANK_LEN   [NUM_LEN] = '{8, 6, 4, 2}, // Prefix length in bytes
	parameter int BANK_NBITS [NUM_LEN] = '{15, 12, 11, 8} // Bitmap address width
) (
	input  logic       clk,
	input  logic       arst_n,
	input  beat_t      din,
	input  logic       din_valid,
	input  bitmap_wr_t wr,
	output res_vec_t   res
);

	window_vec_t win;
	logic        prev_valid;

	window_slicer u_slicer (
		.clk       (clk),
		.arst_n    (arst_n),
		.din       (din),
		.din_valid (din_valid),
		.win       (win),
		.prev_valid(prev_valid)
	);

	// One bank per prefix length, each owns slot j of res
	for (genvar j = 0; j < NUM_LEN; j++) begin : g_bank
		length_bank #(
			.BANK_ID  (j),
			.LEN_BYTES(BANK_LEN[j]),
			.NBITS    (BANK_NBITS[j])
		) u_bank (
			.clk       (clk),
			.arst_n    (arst_n),
			.win       (win),
			.din_valid (din_valid),
			.prev_valid(prev_valid),
			.wr        (wr),
			.res       (res[j])
		);
	end

endmodule

`default_nettype wire

// ==== dv/prefix_filter_checks.svh ====
`ifndef PREFIX_FILTER_CHECKS_SVH
`define PREFIX_FILTER_CHECKS_SVH

int valid_errors = 0; // Mismatches on window valid bits
int hit_errors   = 0; // Mismatches on window hit bits

// Window valid flags of one bank
task automatic check_valid(
	input int       bank,
	input win_res_t got,
	input win_res_t exp
);
	if (got.valid !== exp.valid) begin
		valid_errors++;
		$display("** Error at %0t ns: res[%0d].valid = %b, expected %b",
			$time, bank, got.valid, exp.valid);
	end
endtask

// Window hit flags of one bank
task automatic check_hit(
	input int       bank,
	input win_res_t got,
	input win_res_t exp
);
	if (got.hit !== exp.hit) begin
		hit_errors++;
		$display("** Error at %0t ns: res[%0d].hit = %b, expected %b",
			$time, bank, got.hit, exp.hit);
	end
endtask

`endif

// ==== dv/prefix_filter_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_filter_tb import prefilter_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 10;
	localparam PATTERN_FILE = "dv/prefix_filter_patterns.txt";

	logic       clk;
	logic       arst_n;
	beat_t      din;
	logic       din_valid;
	bitmap_wr_t wr;
	res_vec_t   res;

	int file_errors = 0; // Unreadable or malformed pattern input
	int limit_ns    = 0;

	`include "prefix_filter_checks.svh"

	prefix_filter_top UUT (
		.clk      (clk),
		.arst_n   (arst_n),
		.din      (din),
		.din_valid(din_valid),
		.wr       (wr),
		.res      (res)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Matrix byte b holds bank b with window i in bit i
	task automatic compare_banks(input logic [31:0] exp_v, input logic [31:0] exp_h);
		win_res_t exp;

		for (int b = 0; b < NUM_LEN; b++) begin
			exp.valid = exp_v[8*b +: 8];
			exp.hit   = exp_h[8*b +: 8];
			check_valid(b, res[b], exp);
			check_hit(b, res[b], exp);
		end
	endtask

	function automatic bitmap_wr_t build_write_cmd(
		input logic [31:0] bank,
		input logic [31:0] addr,
		input logic [31:0] value
	);
		bitmap_wr_t cmd;

		cmd.en       = 1'b1;
		cmd.len_sel  = bank[LEN_SEL_W-1:0];
		cmd.bit_addr = addr[MAX_NBITS-1:0];
		cmd.value    = value[0];
		return cmd;
	endfunction

	function automatic int count_pattern_lines();
		int fd;
		int n;
		logic [8*256-1:0] line_buf;

		n  = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line_buf, fd) > 0) begin
				n++;
			end
			$fclose(fd);
		end
		return n;
	endfunction

	initial begin : main
		int               fd;
		int               n;
		int               beats;
		bit               done;
		byte              kind;
		logic [31:0]      f_bank;
		logic [31:0]      f_addr;
		logic [31:0]      f_value;
		logic [63:0]      f_din;
		logic [31:0]      f_valid;
		logic [31:0]      exp_v;
		logic [31:0]      exp_h;
		logic [31:0]      next_v;
		logic [31:0]      next_h;
		bitmap_wr_t       pend_wr;
		logic [8*256-1:0] skip_buf;

		clk       = 1'b0;
		arst_n    = 1'b0;
		din       = '0;
		din_valid = 1'b0;
		wr        = '0;
		pend_wr   = '0;
		exp_v     = '0; // Idle inputs give an all-zero result
		exp_h     = '0;
		beats     = 0;
		done      = 1'b0;
		limit_ns  = (RST_CYCLES + 2 * count_pattern_lines() + 20) * CLK_PERIOD;

		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		compare_banks('0, '0);

		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			file_errors++;
			$display("Could not open the pattern file %s", PATTERN_FILE);
		end else begin
			while (!done && $fscanf(fd, " %c", kind) == 1) begin
				if (kind == "#") begin
					n = $fgets(skip_buf, fd);
				end else if (kind == "W" || kind == "P") begin
					n = $fscanf(fd, "%h %h %h", f_bank, f_addr, f_value);
					if (n != 3) begin
						file_errors++;
						done = 1'b1;
						$display("A write line in the pattern file is incomplete");
					end else if (kind == "P") begin
						pend_wr = build_write_cmd(f_bank, f_addr, f_value); // Rides with next beat
					end else begin
						@(posedge clk);
						din       <= '0;
						din_valid <= 1'b0;
						wr        <= build_write_cmd(f_bank, f_addr, f_value);
						@(negedge clk);
						compare_banks(exp_v, exp_h);
						exp_v = '0;
						exp_h = '0;
					end
				end else if (kind == "B") begin
					n = $fscanf(fd, "%h %h %h %h", f_din, f_valid, next_v, next_h);
					if (n != 4) begin
						file_errors++;
						done = 1'b1;
						$display("A beat line in the pattern file is incomplete");
					end else begin
						@(posedge clk);
						din       <= f_din;
						din_valid <= f_valid[0];
						wr        <= pend_wr;
						pend_wr = '0;
						@(negedge clk);
						compare_banks(exp_v, exp_h); // Result of the line before
						exp_v = next_v;
						exp_h = next_h;
						beats++;
					end
				end else begin
					file_errors++;
					done = 1'b1;
					$display("The pattern file holds a line of unknown kind '%c'", kind);
				end
			end
			$fclose(fd);

			// Last line's result
			@(posedge clk);
			din_valid <= 1'b0;
			wr        <= '0;
			@(negedge clk);
			compare_banks(exp_v, exp_h);

			if (beats == 0) begin
				file_errors++;
				$display("The pattern file holds no beat lines");
			end
		end

		$display("Errors: valid %0d, hit %0d, pattern file %0d",
			valid_errors, hit_errors, file_errors);
		if (valid_errors + hit_errors + file_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: the pattern run did not finish within %0d ns", limit_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/prefix_filter_patterns.txt ====
# Beat lines are B din valid valid_matrix hit_matrix in hex
# Matrix bytes run bank 3 down to bank 0 and bit i of a byte is window i
# Bank lengths are 8 6 4 2 bytes for banks 0 1 2 3
# Write lines are W bank bit_addr value and take an idle cycle of their own
# P lines hold the same write and drive it on the edge of the next B line
# Idle after reset with data on the bus
B 0000000000000000 0 00000000 00000000
B 0123456789abcdef 0 00000000 00000000
# First valid beat gives the staircase and the next one full valid
B 0000000000000000 1 fef8e080 00000000
B 0000000000000000 1 ffffffff 00000000
B 0123456789abcdef 0 00000000 00000000
# Fold addresses of windows that hold 01 in beat byte 3
W 0 0200 1
W 1 001 1
W 2 010 1
W 3 01 1
B 0000000000000000 1 fef8e080 00000000
B 0000000001000000 1 ffffffff 18109080
B 0000000000000000 1 ffffffff 00000000
# Byte 0 stays outside the short prefixes of the hitting windows
B 0000000001000055 1 ffffffff 18108000
B 0000000000000000 1 ffffffff 00000000
B 0000000001000000 1 ffffffff 18109080
B 0000000000000000 1 ffffffff 00000000
# Clear driven with a lookup that still sees the old bit
P 0 0200 0
B 0000000001000000 1 ffffffff 18109080
B 0000000000000000 1 ffffffff 00000000
B 0000000001000000 1 ffffffff 18109000
# Gap then a restart with data in the current beat
B 0000000001000000 0 00000000 00000000
B 0000000001000000 1 fef8e080 18108000
B 0000000000000000 1 ffffffff 00000000
# Window with bytes at both ends of the beat
W 0 009 1
W 1 008 1
B 0000000000000000 1 fef8e080 00000000
B 8000000000000001 1 ffffffff 03029280
# Previous byte 7 lands in the 6 byte prefix of window 2
B 0000000000000000 1 ffffffff 00000400
B 8000000000000001 1 ffffffff 03029280
B 8000000000000001 0 00000000 00000000
B 0000000000000000 1 fef8e080 00000000
# Earlier window against the updated bitmaps
B 0000000001000000 1 ffffffff 18109000
B 0000000000000000 1 ffffffff 00000000
B 0000000000000000 0 00000000 00000000

// ==== vlog.f ====
+incdir+dv
verilog/prefilter_pkg.sv
verilog/window_slicer.sv
verilog/bitmap_table.sv
verilog/length_bank.sv
verilog/prefix_filter_top.sv
dv/prefix_filter_tb.sv

// ==== Bender.yml ====
package:
  name: prefix_filter

sources:
  - files:
      - verilog/prefilter_pkg.sv
      - verilog/window_slicer.sv
      - verilog/bitmap_table.sv
      - verilog/length_bank.sv
      - verilog/prefix_filter_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/prefix_filter_tb.sv
